//--- mcs_mmio_led_config.svh
`ifndef MCS_MMIO_LED_CONFIG_SVH
`define MCS_MMIO_LED_CONFIG_SVH

// Number of LED brightness slots on the MMIO bus
`define MMIO_NUM_SLOTS 4

// MMIO word address, I/O address bits 22 down to 2
`define MMIO_ADDR_W 21

`define MMIO_DATA_W 32

// Duty register and PWM counter width
`define PWM_W 8

// Register offset inside a slot, 32 registers each
`define MMIO_REG_W 5

// Slot number above the register offset
`define MMIO_SLOT_W 6

`endif

//--- mcs_mmio_led_pkg.sv
`default_nettype none

`include "mcs_mmio_led_config.svh"

package mcs_mmio_led_pkg;

    // Register offsets within one slot
    // Any other offset is reserved and reads as zero
    typedef enum logic [`MMIO_REG_W-1:0] {
        REG_DUTY = 0,
        REG_CTRL = 1
    } reg_sel_e;

    // Slot field of the MMIO word address
    typedef logic [`MMIO_SLOT_W-1:0] slot_num_t;

endpackage

`default_nettype wire

//--- mmio_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcs_mmio_led_config.svh"

// Bus between the bridge and the controller blocks
interface mmio_bus_if
    (
        input logic i_clk
    );

    logic                    cs;
    logic                    write;
    logic                    read;
    logic [`MMIO_ADDR_W-1:0] addr;
    logic [`MMIO_DATA_W-1:0] write_data;
    logic [`MMIO_DATA_W-1:0] read_data;

    modport bridge (output cs, write, read, addr, write_data, input read_data);
    modport decoder (input i_clk, cs, write, read, addr, write_data);
    modport mux (input addr, output read_data);

endinterface

// Port of a single peripheral slot
interface mmio_slot_if;

    logic                    cs;
    logic                    write;
    logic                    read;
    logic [`MMIO_REG_W-1:0]  reg_addr;
    logic [`MMIO_DATA_W-1:0] write_data;
    logic [`MMIO_DATA_W-1:0] read_data;

    modport decoder (output cs, write, read, reg_addr, write_data);
    modport core (input cs, write, read, reg_addr, write_data, output read_data);
    modport mux (input read_data);

endinterface

`default_nettype wire

//--- io_mmio_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcs_mmio_led_config.svh"

module io_mmio_bridge
    (
        input  logic                    i_clk,
        input  logic                    i_rst_n,
        // Processor I/O bus
        input  logic                    i_io_addr_strobe,
        input  logic                    i_io_read_strobe,
        input  logic                    i_io_write_strobe,
        input  logic [3:0]              i_io_byte_enable,
        input  logic [31:0]             i_io_address,
        input  logic [`MMIO_DATA_W-1:0] i_io_write_data,
        output logic [`MMIO_DATA_W-1:0] o_io_read_data,
        output logic                    o_io_ready,
        // MMIO bus
        mmio_bus_if.bridge              o_mmio
    );

    logic [`MMIO_DATA_W-1:0] read_data_q;
    logic                    ready_q;

    // Strobes are only valid together with the address strobe
    assign o_mmio.write      = i_io_addr_strobe && i_io_write_strobe;
    assign o_mmio.read       = i_io_addr_strobe && i_io_read_strobe;
    assign o_mmio.cs         = o_mmio.write || o_mmio.read;
    assign o_mmio.addr       = i_io_address[`MMIO_ADDR_W+1:2];
    assign o_mmio.write_data = i_io_write_data;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ready_q     <= 1'b0;
            read_data_q <= '0;
        end else begin
            ready_q <= o_mmio.cs;
            // Held until the next read
            if (o_mmio.read) begin
                read_data_q <= o_mmio.read_data;
            end
        end
    end

    assign o_io_ready     = ready_q;
    assign o_io_read_data = read_data_q;

    // One ready pulse per access
    ready_single_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_io_ready |=> !o_io_ready);

    // Only full-word writes are supported
    word_writes_only: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_mmio.write |-> (i_io_byte_enable == 4'hf));

endmodule

`default_nettype wire

//--- mmio_slot_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcs_mmio_led_config.svh"

module mmio_slot_decoder
    (
        mmio_bus_if.decoder  i_mmio,
        mmio_slot_if.decoder o_slot [`MMIO_NUM_SLOTS]
    );

    mcs_mmio_led_pkg::slot_num_t slot_num;
    logic [`MMIO_NUM_SLOTS-1:0]  slot_cs;

    // Slot field sits just above the register offset
    assign slot_num = i_mmio.addr[`MMIO_REG_W+`MMIO_SLOT_W-1:`MMIO_REG_W];

    for (genvar g = 0; g < `MMIO_NUM_SLOTS; g++) begin : g_slot
        assign slot_cs[g] = i_mmio.cs && (slot_num == mcs_mmio_led_pkg::slot_num_t'(g));

        assign o_slot[g].cs         = slot_cs[g];
        assign o_slot[g].write      = i_mmio.write;
        assign o_slot[g].read       = i_mmio.read;
        assign o_slot[g].reg_addr   = i_mmio.addr[`MMIO_REG_W-1:0];
        assign o_slot[g].write_data = i_mmio.write_data;
    end

    // Unmapped slot numbers select nothing
    one_slot_selected: assert property (@(posedge i_mmio.i_clk)
        $onehot0(slot_cs));

endmodule

`default_nettype wire

//--- mmio_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcs_mmio_led_config.svh"

module mmio_read_mux
    (
        mmio_bus_if.mux  io_mmio,
        mmio_slot_if.mux i_slot [`MMIO_NUM_SLOTS]
    );

    mcs_mmio_led_pkg::slot_num_t slot_num;
    logic [`MMIO_DATA_W-1:0]     slot_rdata [`MMIO_NUM_SLOTS];
    logic [`MMIO_DATA_W-1:0]     read_data;

    assign slot_num = io_mmio.addr[`MMIO_REG_W+`MMIO_SLOT_W-1:`MMIO_REG_W];

    for (genvar g = 0; g < `MMIO_NUM_SLOTS; g++) begin : g_gather
        assign slot_rdata[g] = i_slot[g].read_data;
    end

    // Zero unless the slot number hits an existing slot
    always_comb begin
        read_data = '0;
        for (int i = 0; i < `MMIO_NUM_SLOTS; i++) begin
            if (slot_num == mcs_mmio_led_pkg::slot_num_t'(i)) begin
                read_data = slot_rdata[i];
            end
        end
    end

    assign io_mmio.read_data = read_data;

endmodule

`default_nettype wire

//--- pwm_led_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcs_mmio_led_config.svh"

module pwm_led_core
    (
        input  logic      i_clk,
        input  logic      i_rst_n,
        mmio_slot_if.core io_slot,
        output logic      o_pwm
    );

    logic [`PWM_W-1:0]          duty_q;
    logic                       en_q;
    logic [`PWM_W-1:0]          cnt_q;
    logic [`MMIO_DATA_W-1:0]    reg_val;
    mcs_mmio_led_pkg::reg_sel_e reg_sel;

    assign reg_sel = mcs_mmio_led_pkg::reg_sel_e'(io_slot.reg_addr);

    // Register writes and free-running counter
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            duty_q <= '0;
            en_q   <= 1'b0;
            cnt_q  <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
            if (io_slot.cs && io_slot.write) begin
                case (reg_sel)
                    mcs_mmio_led_pkg::REG_DUTY: duty_q <= io_slot.write_data[`PWM_W-1:0];
                    mcs_mmio_led_pkg::REG_CTRL: en_q   <= io_slot.write_data[0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (reg_sel)
            mcs_mmio_led_pkg::REG_DUTY: reg_val = {{(`MMIO_DATA_W-`PWM_W){1'b0}}, duty_q};
            mcs_mmio_led_pkg::REG_CTRL: reg_val = {{(`MMIO_DATA_W-1){1'b0}}, en_q};
            default:                    reg_val = '0;
        endcase
    end

    assign io_slot.read_data = (io_slot.cs && io_slot.read) ? reg_val : '0;

    // High for duty counts out of every 256
    assign o_pwm = en_q && (cnt_q < duty_q);

    // Clearing the enable bit silences the LED from the next cycle
    disable_forces_low: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (io_slot.cs && io_slot.write && (reg_sel == mcs_mmio_led_pkg::REG_CTRL)
            && !io_slot.write_data[0]) |=> !o_pwm);

endmodule

`default_nettype wire

//--- mcs_mmio_led_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcs_mmio_led_config.svh"

module mcs_mmio_led_top
    (
        input  logic                      i_clk,
        input  logic                      i_rst_n,
        // Processor I/O bus
        input  logic                      i_io_addr_strobe,
        input  logic                      i_io_read_strobe,
        input  logic                      i_io_write_strobe,
        input  logic [3:0]                i_io_byte_enable,
        input  logic [31:0]               i_io_address,
        input  logic [`MMIO_DATA_W-1:0]   i_io_write_data,
        output logic [`MMIO_DATA_W-1:0]   o_io_read_data,
        output logic                      o_io_ready,
        // External
        output logic [`MMIO_NUM_SLOTS-1:0] o_led
    );

    mmio_bus_if  mmio_bus (.i_clk(i_clk));
    mmio_slot_if slot_bus [`MMIO_NUM_SLOTS] ();

    io_mmio_bridge io_mmio_bridge_unit (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_io_addr_strobe(i_io_addr_strobe),
        .i_io_read_strobe(i_io_read_strobe),
        .i_io_write_strobe(i_io_write_strobe),
        .i_io_byte_enable(i_io_byte_enable),
        .i_io_address(i_io_address),
        .i_io_write_data(i_io_write_data),
        .o_io_read_data(o_io_read_data),
        .o_io_ready(o_io_ready),
        .o_mmio(mmio_bus)
    );

    mmio_slot_decoder mmio_slot_decoder_unit (
        .i_mmio(mmio_bus),
        .o_slot(slot_bus)
    );

    // One LED brightness core per slot
    for (genvar g = 0; g < `MMIO_NUM_SLOTS; g++) begin : g_core
        pwm_led_core pwm_led_core_unit (
            .i_clk(i_clk),
            .i_rst_n(i_rst_n),
            .io_slot(slot_bus[g]),
            .o_pwm(o_led[g])
        );
    end

    mmio_read_mux mmio_read_mux_unit (
        .io_mmio(mmio_bus),
        .i_slot(slot_bus)
    );

endmodule

`default_nettype wire

//--- tb_mmio_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcs_mmio_led_config.svh"

module tb_mmio_checker
    (
        input  logic                       i_clk,
        input  logic                       i_rst_n,
        input  logic                       i_io_addr_strobe,
        input  logic                       i_io_read_strobe,
        input  logic                       i_io_write_strobe,
        input  logic [3:0]                 i_io_byte_enable,
        input  logic [31:0]                i_io_address,
        input  logic [31:0]                i_io_write_data,
        input  logic [31:0]                i_io_read_data,
        input  logic                       i_io_ready,
        input  logic [`MMIO_NUM_SLOTS-1:0] i_led
    );

    localparam int NUM_SLOTS = `MMIO_NUM_SLOTS;
    localparam int PERIOD    = 1 << `PWM_W;

    int          errors = 0;
    int          checks = 0;
    logic [7:0]  duty_m [NUM_SLOTS];
    logic        en_m [NUM_SLOTS];
    int          stable_cnt [NUM_SLOTS];
    int          win_cnt [NUM_SLOTS];
    int          high_cnt [NUM_SLOTS];
    logic        pending_ready;
    logic        pending_read;
    logic [31:0] exp_rdata;

    // Slot in I/O address bits 12..7, register offset in bits 6..2
    function automatic logic [31:0] expected_read(input logic [31:0] address);
        int slot;
        int offset;
        slot   = address[12:7];
        offset = address[6:2];
        if (slot >= NUM_SLOTS) begin
            return 32'h0;
        end
        case (offset)
            0:       return {24'h0, duty_m[slot]};
            1:       return {31'h0, en_m[slot]};
            default: return 32'h0;
        endcase
    endfunction

    always @(posedge i_clk) begin
        int slot;
        int expected_high;
        if (!i_rst_n) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                duty_m[s]     = 8'h0;
                en_m[s]       = 1'b0;
                stable_cnt[s] = 0;
                win_cnt[s]    = 0;
                high_cnt[s]   = 0;
            end
            pending_ready = 1'b0;
            pending_read  = 1'b0;
            exp_rdata     = 32'h0;
        end else begin
            checks++;
            if (i_io_ready !== pending_ready) begin
                errors++;
                $display("FAIL %0t: o_io_ready is %b, expected %b", $time, i_io_ready,
                         pending_ready);
            end
            if (pending_read) begin
                checks++;
                if (i_io_read_data !== exp_rdata) begin
                    errors++;
                    $display("FAIL %0t: read data %h, expected %h", $time, i_io_read_data,
                             exp_rdata);
                end
            end

            // LED sample of the cycle that just ended, under the old settings
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (stable_cnt[s] < PERIOD) begin
                    stable_cnt[s]++;
                end else begin
                    high_cnt[s] += i_led[s];
                    win_cnt[s]++;
                    if (win_cnt[s] == PERIOD) begin
                        expected_high = en_m[s] ? duty_m[s] : 0;
                        checks++;
                        if (high_cnt[s] != expected_high) begin
                            errors++;
                            $display("FAIL %0t: LED %0d high %0d of %0d cycles, expected %0d",
                                     $time, s, high_cnt[s], PERIOD, expected_high);
                        end
                        win_cnt[s]  = 0;
                        high_cnt[s] = 0;
                    end
                end
            end

            pending_ready = i_io_addr_strobe && (i_io_read_strobe || i_io_write_strobe);
            pending_read  = i_io_addr_strobe && i_io_read_strobe;
            if (pending_read) begin
                exp_rdata = expected_read(i_io_address);
            end
            if (i_io_addr_strobe && i_io_write_strobe) begin
                slot = i_io_address[12:7];
                if (slot < NUM_SLOTS) begin
                    case (int'(i_io_address[6:2]))
                        0:       duty_m[slot] = i_io_write_data[7:0];
                        1:       en_m[slot]   = i_io_write_data[0];
                        default: ;
                    endcase
                    stable_cnt[slot] = 0;
                    win_cnt[slot]    = 0;
                    high_cnt[slot]   = 0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_mcs_mmio_led.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcs_mmio_led_config.svh"

module tb_mcs_mmio_led;

    localparam int NUM_ACCESSES  = 47;
    localparam int SETTLE_CYCLES = 600;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_io_addr_strobe;
    logic        i_io_read_strobe;
    logic        i_io_write_strobe;
    logic [3:0]  i_io_byte_enable;
    logic [31:0] i_io_address;
    logic [31:0] i_io_write_data;
    wire  [31:0] o_io_read_data;
    wire         o_io_ready;
    wire  [3:0]  o_led;

    int          seed;
    int          bus_errors;
    int          total_errors;
    logic [7:0]  duty [4];

    mcs_mmio_led_top u_dut (.*);

    tb_mmio_checker u_chk (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_io_addr_strobe(i_io_addr_strobe),
        .i_io_read_strobe(i_io_read_strobe),
        .i_io_write_strobe(i_io_write_strobe),
        .i_io_byte_enable(i_io_byte_enable),
        .i_io_address(i_io_address),
        .i_io_write_data(i_io_write_data),
        .i_io_read_data(o_io_read_data),
        .i_io_ready(o_io_ready),
        .i_led(o_led)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    function automatic logic [31:0] io_addr(input int slot, input int offset);
        return {19'h0, slot[5:0], offset[4:0], 2'b00};
    endfunction

    task automatic wait_ready(input string what);
        int cycles;
        cycles = 0;
        while (!o_io_ready && cycles < 4) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_io_ready) begin
            bus_errors++;
            $display("No ready pulse within 4 cycles after a %s at %0t", what, $time);
        end
    endtask

    task automatic io_write(input int slot, input int offset, input logic [31:0] data);
        @(negedge i_clk);
        i_io_addr_strobe  = 1'b1;
        i_io_write_strobe = 1'b1;
        i_io_address      = io_addr(slot, offset);
        i_io_write_data   = data;
        @(negedge i_clk);
        i_io_addr_strobe  = 1'b0;
        i_io_write_strobe = 1'b0;
        wait_ready("write");
    endtask

    task automatic io_read(input int slot, input int offset);
        @(negedge i_clk);
        i_io_addr_strobe = 1'b1;
        i_io_read_strobe = 1'b1;
        i_io_address     = io_addr(slot, offset);
        @(negedge i_clk);
        i_io_addr_strobe = 1'b0;
        i_io_read_strobe = 1'b0;
        wait_ready("read");
    endtask

    // Long enough for 256 stable cycles plus one full PWM window
    task automatic settle();
        repeat (SETTLE_CYCLES) @(negedge i_clk);
    endtask

    initial begin
        seed              = 32'h51d1_b99e;
        bus_errors        = 0;
        i_rst_n           = 1'b0;
        i_io_addr_strobe  = 1'b0;
        i_io_read_strobe  = 1'b0;
        i_io_write_strobe = 1'b0;
        i_io_byte_enable  = 4'hf;
        i_io_address      = 32'h0;
        i_io_write_data   = 32'h0;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        // Everything zero after reset
        for (int s = 0; s < 4; s++) begin
            io_read(s, 0);
            io_read(s, 1);
        end
        settle();

        // Edge duties on slots 0 and 3, distinct random ones in between
        duty[0] = 8'd0;
        duty[3] = 8'd255;
        for (int s = 1; s < 3; s++) begin
            do begin
                duty[s] = 8'($random(seed));
            end while (duty[s] == 8'd0 || duty[s] == 8'd255 || (s == 2 && duty[2] == duty[1]));
        end
        for (int s = 0; s < 4; s++) begin
            io_write(s, 0, {24'h0, duty[s]});
            io_write(s, 1, 32'h1);
        end
        for (int s = 0; s < 4; s++) begin
            io_read(s, 0);
            io_read(s, 1);
        end
        io_read(0, 2);
        io_read(1, 31);
        io_read(2, 5);
        io_read(3, 16);
        settle();

        io_write(2, 1, 32'h0);
        io_read(2, 0);
        io_read(2, 1);
        settle();

        // Unmapped slots
        io_read(5, 0);
        io_read(63, 1);
        io_write(5, 0, 32'h77);
        io_write(63, 1, 32'h0);
        for (int s = 0; s < 4; s++) begin
            io_read(s, 0);
        end
        settle();

        // Back-to-back accesses across slots
        for (int s = 0; s < 4; s++) begin
            io_write(s, 0, {24'h0, duty[3 - s]});
        end
        for (int s = 0; s < 4; s++) begin
            io_read(s, 0);
        end
        settle();

        total_errors = u_chk.errors + bus_errors;
        $display("Errors: %0d (checker %0d, bus %0d), checks: %0d", total_errors,
                 u_chk.errors, bus_errors, u_chk.checks);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (NUM_ACCESSES * SETTLE_CYCLES) @(posedge i_clk);
        $display("Timeout: the run did not finish within %0d cycles",
                 NUM_ACCESSES * SETTLE_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- mcs_mmio_led.f
+incdir+.
mcs_mmio_led_pkg.sv
mmio_if.sv
io_mmio_bridge.sv
mmio_slot_decoder.sv
mmio_read_mux.sv
pwm_led_core.sv
mcs_mmio_led_top.sv
tb_mmio_checker.sv
tb_mcs_mmio_led.sv

//--- Bender.yml
package:
  name: mcs_mmio_led

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mcs_mmio_led_pkg.sv
      - mmio_if.sv
      - io_mmio_bridge.sv
      - mmio_slot_decoder.sv
      - mmio_read_mux.sv
      - pwm_led_core.sv
      - mcs_mmio_led_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mmio_checker.sv
      - tb_mcs_mmio_led.sv
